//--- Bender.yml
package:
  name: fpu_frontend

sources:
  - design/fpu_pkg.sv
  - design/fpu_operand_if.sv
  - design/fpu_issue.sv
  - design/fpu_operand_unpack.sv
  - design/fpu_fcmp.sv
  - design/fpu_f2i.sv
  - design/fpu_result_stage.sv
  - design/fpu_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/fpu_checker.sv
      - dv/fpu_tb.sv

//--- design/fpu_f2i.sv
// fpu_f2i
// float to integer conversion, truncation toward zero.
// stage 1 registers sign, shift amount, fraction and the nan/overflow
// class, output logic then shifts, negates or saturates

`timescale 1ns/1ps

module fpu_f2i (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         flush_i,
  input  logic                         adv_i,
  input  logic                         start_i,
  fpu_operand_if.sink                  ops,
  output logic                         rdy_o,
  output logic [fpu_pkg::FP_WIDTH-1:0] int_o,
  output logic                         ovf_o,
  output logic                         inv_o,
  output logic                         snan_o,
  output logic                         ixf_o
);
  import fpu_pkg::*;

  localparam logic [EXP10_WIDTH-1:0] EXP_INT_TOP = EXP10_WIDTH'(EXP_BIAS + FP_WIDTH - 1);
  localparam logic [EXP10_WIDTH-1:0] EXP_SH_REF  = EXP10_WIDTH'(EXP_BIAS + F2I_XW - 1);

  logic                     nan_d, neg_min_d, ovf_d;
  logic [EXP10_WIDTH-1:0]   sh_full;
  logic [5:0]               sh_d;
  logic                     sign_q, nan_q, snan_q, ovf_q;
  logic [5:0]               sh_q;
  logic [FRACT24_WIDTH-1:0] fract_q;
  logic [F2I_XW-1:0]        x, shr, lost;
  logic [FP_WIDTH-1:0]      mag;

  ////////////////////////////////////////////////////////////
  // stage 1
  ////////////////////////////////////////////////////////////
  assign nan_d     = ops.snan_a | ops.qnan_a;
  assign neg_min_d = ops.sign_a & (ops.exp10_a == EXP_INT_TOP) &
                     (ops.fract24_a == {1'b1, {FRACT_WIDTH{1'b0}}});  // exactly -2^31
  assign ovf_d     = (ops.exp10_a >= EXP_INT_TOP) & ~nan_d & ~neg_min_d;  // incl. inf

  // right shift of {fract24, 31 zeros}, |x| < 1 shifts all out
  assign sh_full = EXP_SH_REF - ops.exp10_a;
  assign sh_d    = ((ops.exp10_a < EXP10_WIDTH'(EXP_BIAS)) | (ops.exp10_a > EXP_INT_TOP)) ?
                   6'(F2I_XW) : sh_full[5:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      rdy_o <= 1'b0;
    end else if (flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= start_i;
    end
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      sign_q  <= ops.sign_a;
      sh_q    <= sh_d;
      fract_q <= ops.fract24_a;
      nan_q   <= nan_d;
      snan_q  <= ops.snan_a;
      ovf_q   <= ovf_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // output logic
  ////////////////////////////////////////////////////////////
  assign x    = {fract_q, {(FP_WIDTH-1){1'b0}}};
  assign shr  = x >> sh_q;
  assign lost = x << (6'(F2I_XW) - sh_q);  // bits below the binary point
  assign mag  = shr[FP_WIDTH-1:0];

  always_comb begin
    int_o = sign_q ? -mag : mag;  // truncated, signed
    ovf_o = 1'b0;
    inv_o = 1'b0;
    ixf_o = |lost;
    if (nan_q) begin
      int_o = INT_MIN_NEG;
      inv_o = 1'b1;
      ixf_o = 1'b0;
    end else if (ovf_q) begin
      int_o = sign_q ? INT_MIN_NEG : INT_MAX_POS;  // saturate
      ovf_o = 1'b1;
      inv_o = 1'b1;
      ixf_o = 1'b0;
    end
  end

  assign snan_o = snan_q;

endmodule

//--- design/fpu_fcmp.sv
// fpu_fcmp
// single-precision comparator, combinational. eq/ne/gt/ge/lt/le with
// optional unordered variant. raises invalid and infinity indications

`timescale 1ns/1ps

module fpu_fcmp (
  input  logic              start_i,
  input  fpu_pkg::cmp_sel_e cmp_sel_i,
  input  logic              unord_i,
  fpu_operand_if.sink       ops,
  output logic              rdy_o,
  output logic              flag_o,
  output logic              inv_o,
  output logic              inf_o
);
  import fpu_pkg::*;

  logic any_nan, any_snan;
  logic both_zero;     // +0 == -0
  logic mag_gt;        // |a| > |b|
  logic mag_eq;        // |a| == |b|
  logic a_eq_b, a_gt_b;
  logic ordered_cmp;   // gt, ge, lt, le
  logic ord_flag;

  assign any_snan  = ops.snan_a | ops.snan_b;
  assign any_nan   = any_snan | ops.qnan_a | ops.qnan_b;
  assign both_zero = ops.zero_a & ops.zero_b;

  // magnitude by exponent first, then fraction
  assign mag_eq = (ops.exp10_a == ops.exp10_b) & (ops.fract24_a == ops.fract24_b);
  assign mag_gt = (ops.exp10_a > ops.exp10_b) |
                  ((ops.exp10_a == ops.exp10_b) & (ops.fract24_a > ops.fract24_b));

  assign a_eq_b = both_zero | (mag_eq & (ops.sign_a == ops.sign_b));

  always_comb begin
    if (both_zero) begin
      a_gt_b = 1'b0;
    end else if (ops.sign_a != ops.sign_b) begin
      a_gt_b = ops.sign_b;  // a positive, b negative
    end else if (ops.sign_a) begin
      a_gt_b = ~mag_gt & ~mag_eq;  // both negative, smaller mag wins
    end else begin
      a_gt_b = mag_gt;
    end
  end

  always_comb begin
    case (cmp_sel_i)
      CMP_EQ:  ord_flag = a_eq_b;
      CMP_NE:  ord_flag = ~a_eq_b;
      CMP_GT:  ord_flag = a_gt_b;
      CMP_GE:  ord_flag = a_gt_b | a_eq_b;
      CMP_LT:  ord_flag = ~a_gt_b & ~a_eq_b;
      CMP_LE:  ord_flag = ~a_gt_b;
      default: ord_flag = 1'b0;  // codes 6, 7 unused
    endcase
  end

  assign ordered_cmp = (cmp_sel_i == CMP_GT) | (cmp_sel_i == CMP_GE) |
                       (cmp_sel_i == CMP_LT) | (cmp_sel_i == CMP_LE);

  // a nan makes the compare unordered
  assign flag_o = any_nan ? unord_i : ord_flag;
  assign inv_o  = any_snan | (any_nan & ordered_cmp);
  assign inf_o  = ops.inf_a | ops.inf_b;
  assign rdy_o  = start_i;

endmodule

//--- design/fpu_issue.sv
// fpu_issue
// start logic of the fpu front end. captures operands and opcode on
// the decode strobe and raises the start of the unit the opcode names

`timescale 1ns/1ps

module fpu_issue (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             flush_i,
  input  logic                             padv_decode_i,
  input  logic                             adv_i,
  input  logic [fpu_pkg::FPUOP_WIDTH-1:0]  op_fpu_i,
  input  logic [fpu_pkg::FP_WIDTH-1:0]     rfa_i,
  input  logic [fpu_pkg::FP_WIDTH-1:0]     rfb_i,
  output logic [fpu_pkg::FP_WIDTH-1:0]     opa_o,
  output logic [fpu_pkg::FP_WIDTH-1:0]     opb_o,
  output logic                             cmp_start_o,
  output logic                             f2i_start_o,
  output fpu_pkg::cmp_sel_e                cmp_sel_o,
  output logic                             unord_o
);
  import fpu_pkg::*;

  logic       decode_fpu;  // decode strobe for an fpu op
  logic       new_data;    // captured op not yet taken by the units
  logic       cmp_q;       // compare bit
  logic       unord_q;     // unordered variant
  logic [2:0] code_q;      // low opcode field

  assign decode_fpu = padv_decode_i & op_fpu_i[OP_VALID_BIT];

  always_ff @(posedge clk) begin
    if (rst) begin
      new_data <= 1'b0;
    end else if (flush_i) begin
      new_data <= 1'b0;
    end else if (decode_fpu) begin
      new_data <= 1'b1;
    end else if (adv_i) begin
      new_data <= 1'b0;  // units took it
    end
  end

  // operand and opcode capture
  always_ff @(posedge clk) begin
    if (decode_fpu) begin
      opa_o   <= rfa_i;
      opb_o   <= rfb_i;
      cmp_q   <= op_fpu_i[OP_CMP_BIT];
      unord_q <= op_fpu_i[OP_UNORD_BIT];
      code_q  <= op_fpu_i[2:0];
    end
  end

  // unit select, codes 0..4 without cmp bit start nothing
  assign cmp_start_o = new_data & cmp_q;
  assign f2i_start_o = new_data & ~cmp_q & (code_q == OP_F2I);
  assign cmp_sel_o   = cmp_sel_e'(code_q);
  assign unord_o     = unord_q;

endmodule

//--- design/fpu_operand_if.sv
// fpu_operand_if
// classified operands a and b, from the unpacker to the units

`timescale 1ns/1ps

interface fpu_operand_if;
  import fpu_pkg::*;

  logic                     sign_a, sign_b;
  logic [EXP10_WIDTH-1:0]   exp10_a, exp10_b;    // restored exponent
  logic [FRACT24_WIDTH-1:0] fract24_a, fract24_b; // with hidden bit
  logic                     snan_a, snan_b;
  logic                     qnan_a, qnan_b;
  logic                     inf_a, inf_b;
  logic                     zero_a, zero_b;

  modport source (
    output sign_a, exp10_a, fract24_a, snan_a, qnan_a, inf_a, zero_a,
    output sign_b, exp10_b, fract24_b, snan_b, qnan_b, inf_b, zero_b
  );

  modport sink (
    input sign_a, exp10_a, fract24_a, snan_a, qnan_a, inf_a, zero_a,
    input sign_b, exp10_b, fract24_b, snan_b, qnan_b, inf_b, zero_b
  );

endinterface

//--- design/fpu_operand_unpack.sv
// fpu_operand_unpack
// splits both captured operands into fields and classifies them
// (inf, snan, qnan, zero, denormal). restores hidden bit and exponent

`timescale 1ns/1ps

module fpu_operand_unpack (
  input  logic [fpu_pkg::FP_WIDTH-1:0] opa_i,
  input  logic [fpu_pkg::FP_WIDTH-1:0] opb_i,
  fpu_operand_if.source                ops
);
  import fpu_pkg::*;

  logic [EXP_WIDTH-1:0]   exp_a, exp_b;
  logic [FRACT_WIDTH-1:0] fract_a, fract_b;
  logic                   exp_ff_a, exp_ff_b;  // all ones exponent
  logic                   dn_a, dn_b;          // denormal

  // operand a
  assign exp_a         = opa_i[FP_WIDTH-2 -: EXP_WIDTH];
  assign fract_a       = opa_i[FRACT_WIDTH-1:0];
  assign exp_ff_a      = &exp_a;
  assign dn_a          = ~(|exp_a) & (|fract_a);
  assign ops.sign_a    = opa_i[FP_WIDTH-1];
  assign ops.inf_a     = exp_ff_a & ~(|fract_a);
  assign ops.snan_a    = exp_ff_a & ~fract_a[FRACT_WIDTH-1] & (|fract_a[FRACT_WIDTH-2:0]);
  assign ops.qnan_a    = exp_ff_a & fract_a[FRACT_WIDTH-1];  // msb of fraction set
  assign ops.zero_a    = ~(|opa_i[FP_WIDTH-2:0]);
  assign ops.exp10_a   = {2'b00, exp_a[EXP_WIDTH-1:1], exp_a[0] | dn_a};  // denormal as 1
  assign ops.fract24_a = {|exp_a, fract_a};  // hidden bit

  // operand b
  assign exp_b         = opb_i[FP_WIDTH-2 -: EXP_WIDTH];
  assign fract_b       = opb_i[FRACT_WIDTH-1:0];
  assign exp_ff_b      = &exp_b;
  assign dn_b          = ~(|exp_b) & (|fract_b);
  assign ops.sign_b    = opb_i[FP_WIDTH-1];
  assign ops.inf_b     = exp_ff_b & ~(|fract_b);
  assign ops.snan_b    = exp_ff_b & ~fract_b[FRACT_WIDTH-1] & (|fract_b[FRACT_WIDTH-2:0]);
  assign ops.qnan_b    = exp_ff_b & fract_b[FRACT_WIDTH-1];
  assign ops.zero_b    = ~(|opb_i[FP_WIDTH-2:0]);
  assign ops.exp10_b   = {2'b00, exp_b[EXP_WIDTH-1:1], exp_b[0] | dn_b};
  assign ops.fract24_b = {|exp_b, fract_b};

endmodule

//--- design/fpu_pkg.sv
// fpu_pkg
// shared formats, opcode fields, compare codes and flag positions
// for the single-precision compare and f2i front end

package fpu_pkg;

  ////////////////////////////////////////////////////////////
  // ieee single format
  ////////////////////////////////////////////////////////////
  localparam int FP_WIDTH      = 32;
  localparam int EXP_WIDTH     = 8;
  localparam int FRACT_WIDTH   = 23;
  localparam int EXP10_WIDTH   = 10;  // restored exponent
  localparam int FRACT24_WIDTH = 24;  // fraction plus hidden bit
  localparam int EXP_BIAS      = 127;

  // f2i working width, fraction over the integer range
  localparam int F2I_XW = FRACT24_WIDTH + FP_WIDTH - 1;

  ////////////////////////////////////////////////////////////
  // opcode
  ////////////////////////////////////////////////////////////
  localparam int FPUOP_WIDTH  = 8;
  localparam int OP_VALID_BIT = 7;  // set by decode for any fpu op
  localparam int OP_CMP_BIT   = 3;
  localparam int OP_UNORD_BIT = 5;  // unordered compare variant

  localparam logic [2:0] OP_F2I = 3'd5;  // low field, cmp bit clear

  typedef enum logic [2:0] {
    CMP_EQ = 3'd0,
    CMP_NE = 3'd1,
    CMP_GT = 3'd2,
    CMP_GE = 3'd3,
    CMP_LT = 3'd4,
    CMP_LE = 3'd5
  } cmp_sel_e;

  ////////////////////////////////////////////////////////////
  // fpcsr flag word
  ////////////////////////////////////////////////////////////
  localparam int FLAG_WIDTH = 6;
  localparam int FLAG_OVF   = 0;  // overflow
  localparam int FLAG_SNF   = 1;  // snan seen
  localparam int FLAG_ZF    = 2;  // zero result
  localparam int FLAG_IXF   = 3;  // inexact
  localparam int FLAG_IVF   = 4;  // invalid
  localparam int FLAG_INF   = 5;  // infinity operand

  // f2i saturation values
  localparam logic [FP_WIDTH-1:0] INT_MAX_POS = 32'h7fff_ffff;
  localparam logic [FP_WIDTH-1:0] INT_MIN_NEG = 32'h8000_0000;

endpackage

//--- design/fpu_result_stage.sv
// fpu_result_stage
// held output registers of the fpu. registers whichever unit is ready,
// packs result and fpcsr flags and holds them until execute advance

`timescale 1ns/1ps

module fpu_result_stage (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           flush_i,
  input  logic                           padv_execute_i,
  input  logic                           cmp_rdy_i,
  input  logic                           cmp_flag_i,
  input  logic                           cmp_inv_i,
  input  logic                           cmp_inf_i,
  input  logic                           f2i_rdy_i,
  input  logic [fpu_pkg::FP_WIDTH-1:0]   f2i_int_i,
  input  logic                           f2i_ovf_i,
  input  logic                           f2i_inv_i,
  input  logic                           f2i_snan_i,
  input  logic                           f2i_ixf_i,
  output logic                           adv_o,
  output logic [fpu_pkg::FP_WIDTH-1:0]   fpu_result_o,
  output logic                           fpu_arith_valid_o,
  output logic                           fpu_cmp_flag_o,
  output logic                           fpu_cmp_valid_o,
  output logic [fpu_pkg::FLAG_WIDTH-1:0] fpcsr_o
);
  import fpu_pkg::*;

  logic [FLAG_WIDTH-1:0] flags_d;

  // advance unless a result is held and not taken
  assign adv_o = padv_execute_i | ~(fpu_arith_valid_o | fpu_cmp_valid_o);

  // flag word, f2i has priority as the older op
  always_comb begin
    flags_d = '0;
    if (f2i_rdy_i) begin
      flags_d[FLAG_OVF] = f2i_ovf_i;
      flags_d[FLAG_SNF] = f2i_snan_i;
      flags_d[FLAG_ZF]  = ~(|f2i_int_i);
      flags_d[FLAG_IXF] = f2i_ixf_i;
      flags_d[FLAG_IVF] = f2i_inv_i;
    end else begin
      flags_d[FLAG_IVF] = cmp_inv_i;
      flags_d[FLAG_INF] = cmp_inf_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fpu_arith_valid_o <= 1'b0;
      fpu_cmp_valid_o   <= 1'b0;
    end else if (flush_i) begin
      fpu_arith_valid_o <= 1'b0;
      fpu_cmp_valid_o   <= 1'b0;
    end else if (adv_o) begin
      fpu_arith_valid_o <= f2i_rdy_i;
      fpu_cmp_valid_o   <= cmp_rdy_i & ~f2i_rdy_i;
    end
  end

  always_ff @(posedge clk) begin
    if (adv_o & (f2i_rdy_i | cmp_rdy_i)) begin
      fpu_result_o   <= f2i_rdy_i ? f2i_int_i : '0;
      fpu_cmp_flag_o <= cmp_flag_i & ~f2i_rdy_i;
      fpcsr_o        <= flags_d;
    end
  end

endmodule

//--- design/fpu_top.sv
// fpu_top
// single-precision fpu front end with compare and f2i units.
// issue -> unpack -> fcmp / f2i -> held result stage

`timescale 1ns/1ps

module fpu_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            flush_i,
  input  logic                            padv_decode_i,
  input  logic                            padv_execute_i,
  input  logic [fpu_pkg::FPUOP_WIDTH-1:0] op_fpu_i,
  input  logic [fpu_pkg::FP_WIDTH-1:0]    rfa_i,
  input  logic [fpu_pkg::FP_WIDTH-1:0]    rfb_i,
  output logic [fpu_pkg::FP_WIDTH-1:0]    fpu_result_o,
  output logic                            fpu_arith_valid_o,
  output logic                            fpu_cmp_flag_o,
  output logic                            fpu_cmp_valid_o,
  output logic [fpu_pkg::FLAG_WIDTH-1:0]  fpcsr_o
);
  import fpu_pkg::*;

  logic [FP_WIDTH-1:0] opa, opb;  // captured operands
  logic                cmp_start, f2i_start, unord, adv;
  cmp_sel_e            cmp_sel;
  logic                cmp_rdy, cmp_flag, cmp_inv, cmp_inf;
  logic                f2i_rdy, f2i_ovf, f2i_inv, f2i_snan, f2i_ixf;
  logic [FP_WIDTH-1:0] f2i_int;

  fpu_operand_if ops ();

  fpu_issue u_issue (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .padv_decode_i (padv_decode_i),
    .adv_i         (adv),
    .op_fpu_i      (op_fpu_i),
    .rfa_i         (rfa_i),
    .rfb_i         (rfb_i),
    .opa_o         (opa),
    .opb_o         (opb),
    .cmp_start_o   (cmp_start),
    .f2i_start_o   (f2i_start),
    .cmp_sel_o     (cmp_sel),
    .unord_o       (unord)
  );

  fpu_operand_unpack u_unpack (
    .opa_i (opa),
    .opb_i (opb),
    .ops   (ops.source)
  );

  fpu_fcmp u_fcmp (
    .start_i   (cmp_start),
    .cmp_sel_i (cmp_sel),
    .unord_i   (unord),
    .ops       (ops.sink),
    .rdy_o     (cmp_rdy),
    .flag_o    (cmp_flag),
    .inv_o     (cmp_inv),
    .inf_o     (cmp_inf)
  );

  fpu_f2i u_f2i (
    .clk     (clk),
    .rst     (rst),
    .flush_i (flush_i),
    .adv_i   (adv),
    .start_i (f2i_start),
    .ops     (ops.sink),
    .rdy_o   (f2i_rdy),
    .int_o   (f2i_int),
    .ovf_o   (f2i_ovf),
    .inv_o   (f2i_inv),
    .snan_o  (f2i_snan),
    .ixf_o   (f2i_ixf)
  );

  fpu_result_stage u_result (
    .clk               (clk),
    .rst               (rst),
    .flush_i           (flush_i),
    .padv_execute_i    (padv_execute_i),
    .cmp_rdy_i         (cmp_rdy),
    .cmp_flag_i        (cmp_flag),
    .cmp_inv_i         (cmp_inv),
    .cmp_inf_i         (cmp_inf),
    .f2i_rdy_i         (f2i_rdy),
    .f2i_int_i         (f2i_int),
    .f2i_ovf_i         (f2i_ovf),
    .f2i_inv_i         (f2i_inv),
    .f2i_snan_i        (f2i_snan),
    .f2i_ixf_i         (f2i_ixf),
    .adv_o             (adv),
    .fpu_result_o      (fpu_result_o),
    .fpu_arith_valid_o (fpu_arith_valid_o),
    .fpu_cmp_flag_o    (fpu_cmp_flag_o),
    .fpu_cmp_valid_o   (fpu_cmp_valid_o),
    .fpcsr_o           (fpcsr_o)
  );

endmodule

//--- dv/fpu_vectors.svh
// fpu test vectors
// one row per op: opcode, operands, stall before execute advance,
// expected output kind, flush after issue, expected result, compare
// flag and fpcsr (ovf bit 0, snf 1, zf 2, ixf 3, ivf 4, inf 5)

typedef struct packed {
  logic [7:0]  op;
  logic [31:0] a;
  logic [31:0] b;
  logic [3:0]  stall;  // cycles execute advance stays low
  logic [1:0]  kind;   // which valid output is expected
  logic        flush;  // flush one cycle after issue
  logic [31:0] res;
  logic        flag;
  logic [5:0]  csr;
} vec_t;

localparam logic [1:0] K_NONE = 2'd0;  // no output at all
localparam logic [1:0] K_CMP  = 2'd1;
localparam logic [1:0] K_F2I  = 2'd2;

// opcodes, bit 7 fpu op, bit 3 compare, bit 5 unordered
localparam logic [7:0] FEQ  = 8'h88;
localparam logic [7:0] FNE  = 8'h89;
localparam logic [7:0] FGT  = 8'h8a;
localparam logic [7:0] FGE  = 8'h8b;
localparam logic [7:0] FLT  = 8'h8c;
localparam logic [7:0] FLE  = 8'h8d;
localparam logic [7:0] FUEQ = 8'ha8;
localparam logic [7:0] FUGT = 8'haa;
localparam logic [7:0] FULT = 8'hac;
localparam logic [7:0] FTOI = 8'h85;

localparam logic [31:0] F_P1   = 32'h3f80_0000;  // 1.0
localparam logic [31:0] F_P2   = 32'h4000_0000;  // 2.0
localparam logic [31:0] F_M1   = 32'hbf80_0000;
localparam logic [31:0] F_M2   = 32'hc000_0000;
localparam logic [31:0] F_PZ   = 32'h0000_0000;
localparam logic [31:0] F_MZ   = 32'h8000_0000;
localparam logic [31:0] F_PINF = 32'h7f80_0000;
localparam logic [31:0] F_MINF = 32'hff80_0000;
localparam logic [31:0] F_QNAN = 32'h7fc0_0000;
localparam logic [31:0] F_SNAN = 32'h7fa0_0000;  // fraction msb clear

localparam int NUM_VECS = 46;

localparam vec_t VECS [NUM_VECS] = '{
  // ordered compares
  {FEQ,  F_P1,   F_P1,   4'd0, K_CMP, 1'b0, 32'h0, 1'b1, 6'h00},
  {FNE,  F_P1,   F_P2,   4'd0, K_CMP, 1'b0, 32'h0, 1'b1, 6'h00},
  {FGT,  F_P1,   F_P2,   4'd0, K_CMP, 1'b0, 32'h0, 1'b0, 6'h00},
  {FGT,  F_P2,   F_P1,   4'd0, K_CMP, 1'b0, 32'h0, 1'b1, 6'h00},
  {FLT,  F_M1,   F_P1,   4'd0, K_CMP, 1'b0, 32'h0, 1'b1, 6'h00},
  {FLT,  F_M2,   F_M1,   4'd0, K_CMP, 1'b0, 32'h0, 1'b1, 6'h00},  // both negative
  {FGE,  F_M1,   F_M2,   4'd0, K_CMP, 1'b0, 32'h0, 1'b1, 6'h00},
  {FLE,  F_P1,   F_P1,   4'd0, K_CMP, 1'b0, 32'h0, 1'b1, 6'h00},
  {FEQ,  F_PZ,   F_MZ,   4'd0, K_CMP, 1'b0, 32'h0, 1'b1, 6'h00},  // +0 == -0
  {FLT,  F_MZ,   F_PZ,   4'd0, K_CMP, 1'b0, 32'h0, 1'b0, 6'h00},
  {FGT,  F_PINF, F_P1,   4'd0, K_CMP, 1'b0, 32'h0, 1'b1, 6'h20},  // inf operand
  {FLT,  F_MINF, F_M2,   4'd0, K_CMP, 1'b0, 32'h0, 1'b1, 6'h20},
  {FEQ,  F_PINF, F_PINF, 4'd0, K_CMP, 1'b0, 32'h0, 1'b1, 6'h20},
  {FLE,  F_P1,   F_MINF, 4'd0, K_CMP, 1'b0, 32'h0, 1'b0, 6'h20},
  // nan operands
  {FEQ,  F_QNAN, F_P1,   4'd0, K_CMP, 1'b0, 32'h0, 1'b0, 6'h00},
  {FNE,  F_QNAN, F_P1,   4'd0, K_CMP, 1'b0, 32'h0, 1'b0, 6'h00},
  {FGT,  F_P1,   F_QNAN, 4'd0, K_CMP, 1'b0, 32'h0, 1'b0, 6'h10},  // ivf on ordered
  {FLE,  F_QNAN, F_P1,   4'd0, K_CMP, 1'b0, 32'h0, 1'b0, 6'h10},
  {FEQ,  F_SNAN, F_P1,   4'd0, K_CMP, 1'b0, 32'h0, 1'b0, 6'h10},  // snan always ivf
  {FUEQ, F_QNAN, F_P1,   4'd0, K_CMP, 1'b0, 32'h0, 1'b1, 6'h00},
  {FULT, F_P1,   F_QNAN, 4'd0, K_CMP, 1'b0, 32'h0, 1'b1, 6'h10},
  {FUEQ, F_P1,   F_P2,   4'd0, K_CMP, 1'b0, 32'h0, 1'b0, 6'h00},  // ordered operands
  {FUGT, F_SNAN, F_PINF, 4'd0, K_CMP, 1'b0, 32'h0, 1'b1, 6'h30},
  // f2i, truncation toward zero
  {FTOI, 32'h4070_0000, F_PZ, 4'd0, K_F2I, 1'b0, 32'h0000_0003, 1'b0, 6'h08},  // 3.75
  {FTOI, F_M2,          F_PZ, 4'd0, K_F2I, 1'b0, 32'hffff_fffe, 1'b0, 6'h00},
  {FTOI, 32'h3e80_0000, F_PZ, 4'd0, K_F2I, 1'b0, 32'h0000_0000, 1'b0, 6'h0c},  // 0.25
  {FTOI, 32'h0000_0001, F_PZ, 4'd0, K_F2I, 1'b0, 32'h0000_0000, 1'b0, 6'h0c},  // denormal
  {FTOI, F_MZ,          F_PZ, 4'd0, K_F2I, 1'b0, 32'h0000_0000, 1'b0, 6'h04},
  {FTOI, 32'hbfc0_0000, F_PZ, 4'd0, K_F2I, 1'b0, 32'hffff_ffff, 1'b0, 6'h08},  // -1.5
  {FTOI, 32'h4e80_0000, F_PZ, 4'd0, K_F2I, 1'b0, 32'h4000_0000, 1'b0, 6'h00},  // 2^30
  // f2i saturation and nan
  {FTOI, 32'h4f00_0000, F_PZ, 4'd0, K_F2I, 1'b0, 32'h7fff_ffff, 1'b0, 6'h11},  // 2^31
  {FTOI, 32'hcf80_0000, F_PZ, 4'd0, K_F2I, 1'b0, 32'h8000_0000, 1'b0, 6'h11},  // -2^32
  {FTOI, F_PINF,        F_PZ, 4'd0, K_F2I, 1'b0, 32'h7fff_ffff, 1'b0, 6'h11},
  {FTOI, F_MINF,        F_PZ, 4'd0, K_F2I, 1'b0, 32'h8000_0000, 1'b0, 6'h11},
  {FTOI, 32'hcf00_0000, F_PZ, 4'd0, K_F2I, 1'b0, 32'h8000_0000, 1'b0, 6'h00},  // -2^31 exact
  {FTOI, F_QNAN,        F_PZ, 4'd0, K_F2I, 1'b0, 32'h8000_0000, 1'b0, 6'h10},
  {FTOI, 32'hffa0_0000, F_PZ, 4'd0, K_F2I, 1'b0, 32'h8000_0000, 1'b0, 6'h12},  // -snan
  // back-pressure
  {FGE,  F_P2,          F_P2, 4'd3, K_CMP, 1'b0, 32'h0,         1'b1, 6'h00},
  {FTOI, 32'h4070_0000, F_PZ, 4'd5, K_F2I, 1'b0, 32'h0000_0003, 1'b0, 6'h08},
  // no output expected
  {8'h05, F_P1, F_P1, 4'd0, K_NONE, 1'b0, 32'h0, 1'b0, 6'h00},  // bit 7 clear
  {8'h80, F_P1, F_P1, 4'd0, K_NONE, 1'b0, 32'h0, 1'b0, 6'h00},  // dropped units
  {8'h84, F_P1, F_P1, 4'd0, K_NONE, 1'b0, 32'h0, 1'b0, 6'h00},
  {8'h86, F_P1, F_P1, 4'd0, K_NONE, 1'b0, 32'h0, 1'b0, 6'h00},
  {FGT,  F_P2, F_P1,  4'd0, K_NONE, 1'b1, 32'h0, 1'b0, 6'h00},  // flushed compare
  {FTOI, F_P2, F_PZ,  4'd0, K_NONE, 1'b1, 32'h0, 1'b0, 6'h00},  // flushed f2i
  {FTOI, 32'h3fc0_0000, F_PZ, 4'd0, K_F2I, 1'b0, 32'h0000_0001, 1'b0, 6'h08}
};

//--- dv/fpu_checker.sv
// fpu_checker
// watches the fpu outputs, compares each new result with the vector
// table, checks output latency and the hold under back-pressure

`timescale 1ns/1ps

module fpu_checker (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           padv_decode_i,
  input  logic                           padv_execute_i,
  input  int                             vec_idx_i,
  input  logic [fpu_pkg::FP_WIDTH-1:0]   fpu_result_i,
  input  logic                           fpu_arith_valid_i,
  input  logic                           fpu_cmp_flag_i,
  input  logic                           fpu_cmp_valid_i,
  input  logic [fpu_pkg::FLAG_WIDTH-1:0] fpcsr_i,
  output int                             results_o,
  output int                             value_errors_o,
  output int                             proto_errors_o
);
  import fpu_pkg::*;

  `include "fpu_vectors.svh"

  int                    cyc;        // rising edges seen
  int                    cur;        // vector under test
  int                    issue_cyc;
  logic                  pending;    // issued, no output yet
  logic                  prev_arith, prev_cmp, prev_flag, prev_exec;
  logic [FP_WIDTH-1:0]   prev_res;
  logic [FLAG_WIDTH-1:0] prev_csr;

  initial begin
    cyc            = 0;
    cur            = 0;
    issue_cyc      = 0;
    results_o      = 0;
    value_errors_o = 0;
    proto_errors_o = 0;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic check_result();
    vec_t v;
    int   lat;
    v = VECS[cur];
    results_o++;
    if (!pending || (v.kind == K_NONE)) begin
      proto_errors_o++;
      $display("unexpected output at %0t, vector %0d should give none", $time, cur);
    end else begin
      lat = (v.kind == K_F2I) ? 2 : 1;  // compare 1, f2i 2
      if (fpu_arith_valid_i !== (v.kind == K_F2I) || fpu_cmp_valid_i !== (v.kind == K_CMP)) begin
        proto_errors_o++;
        $display("wrong valid output at %0t for vector %0d", $time, cur);
      end
      if (cyc - issue_cyc != lat + 1) begin  // issue seen a cycle before capture
        proto_errors_o++;
        $display("vector %0d output after %0d cycles, expected %0d", cur,
                 cyc - issue_cyc - 1, lat);
      end
      if (fpu_result_i !== v.res || fpu_cmp_flag_i !== v.flag || fpcsr_i !== v.csr) begin
        value_errors_o++;
        $display("[ERROR] %0t: vector %0d result %h flag %b fpcsr %b, expected %h %b %b",
                 $time, cur, fpu_result_i, fpu_cmp_flag_i, fpcsr_i, v.res, v.flag, v.csr);
      end
    end
    pending = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // sampled on the falling edge where inputs and outputs are stable
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (rst) begin
      pending    = 1'b0;
      prev_arith = 1'b0;
      prev_cmp   = 1'b0;
      prev_exec  = 1'b0;
    end else begin
      if (padv_decode_i) begin  // capture on next rising edge
        cur       = vec_idx_i;
        issue_cyc = cyc;
        pending   = 1'b1;
      end
      // held output must not move without execute advance
      if ((prev_arith | prev_cmp) & ~prev_exec) begin
        if (fpu_arith_valid_i !== prev_arith || fpu_cmp_valid_i !== prev_cmp ||
            fpu_result_i !== prev_res || fpu_cmp_flag_i !== prev_flag ||
            fpcsr_i !== prev_csr) begin
          value_errors_o++;
          $display("[ERROR] %0t: held output changed while execute advance was low", $time);
        end
      end
      // execute advance takes the held result
      if ((prev_arith | prev_cmp) & prev_exec) begin
        if (fpu_arith_valid_i !== 1'b0 || fpu_cmp_valid_i !== 1'b0) begin
          proto_errors_o++;
          $display("valid output still high at %0t after execute advance", $time);
        end
      end
      if ((fpu_arith_valid_i & ~prev_arith) | (fpu_cmp_valid_i & ~prev_cmp)) begin
        check_result();
      end
      prev_arith = fpu_arith_valid_i;
      prev_cmp   = fpu_cmp_valid_i;
      prev_res   = fpu_result_i;
      prev_flag  = fpu_cmp_flag_i;
      prev_csr   = fpcsr_i;
      prev_exec  = padv_execute_i;  // value seen by the next rising edge
    end
  end

endmodule

//--- dv/fpu_tb.sv
// fpu_tb
// testbench of the fpu front end. clock, reset, table-driven driver,
// cycle-count timeout and closing report, comparing is in fpu_checker

`timescale 1ns/1ps

module fpu_tb;
  import fpu_pkg::*;

  `include "fpu_vectors.svh"

  logic                   clk, rst, flush;
  logic                   padv_decode, padv_execute;
  logic [FPUOP_WIDTH-1:0] op_fpu;
  logic [FP_WIDTH-1:0]    rfa, rfb;
  logic [FP_WIDTH-1:0]    fpu_result;
  logic                   fpu_arith_valid, fpu_cmp_flag, fpu_cmp_valid;
  logic [FLAG_WIDTH-1:0]  fpcsr;
  int                     vec_idx;                  // row being driven
  int                     results, value_errors, proto_errors;
  int                     cycles, limit;

  fpu_top dut0 (
    .clk               (clk),
    .rst               (rst),
    .flush_i           (flush),
    .padv_decode_i     (padv_decode),
    .padv_execute_i    (padv_execute),
    .op_fpu_i          (op_fpu),
    .rfa_i             (rfa),
    .rfb_i             (rfb),
    .fpu_result_o      (fpu_result),
    .fpu_arith_valid_o (fpu_arith_valid),
    .fpu_cmp_flag_o    (fpu_cmp_flag),
    .fpu_cmp_valid_o   (fpu_cmp_valid),
    .fpcsr_o           (fpcsr)
  );

  fpu_checker u_checker (
    .clk               (clk),
    .rst               (rst),
    .padv_decode_i     (padv_decode),
    .padv_execute_i    (padv_execute),
    .vec_idx_i         (vec_idx),
    .fpu_result_i      (fpu_result),
    .fpu_arith_valid_i (fpu_arith_valid),
    .fpu_cmp_flag_i    (fpu_cmp_flag),
    .fpu_cmp_valid_i   (fpu_cmp_valid),
    .fpcsr_i           (fpcsr),
    .results_o         (results),
    .value_errors_o    (value_errors),
    .proto_errors_o    (proto_errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  ////////////////////////////////////////////////////////////
  // timeout
  ////////////////////////////////////////////////////////////
  initial begin : watchdog
    int max_stall;
    max_stall = 0;
    for (int i = 0; i < NUM_VECS; i++) begin
      if (VECS[i].stall > max_stall) begin
        max_stall = VECS[i].stall;
      end
    end
    limit  = NUM_VECS * (4 + max_stall) + 16 + 50;  // reset plus margin
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, a valid output never arrived", limit);
    $display("ERRORS FOUND");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // driver, inputs change 2 ns after the rising edge
  ////////////////////////////////////////////////////////////
  initial begin : driver
    vec_t v;
    rst          = 1'b1;
    flush        = 1'b0;
    padv_decode  = 1'b0;
    padv_execute = 1'b0;
    op_fpu       = '0;
    rfa          = '0;
    rfb          = '0;
    vec_idx      = 0;
    repeat (16) @(posedge clk);
    #2 rst = 1'b0;
    for (int i = 0; i < NUM_VECS; i++) begin
      v = VECS[i];
      @(posedge clk);
      #2;
      vec_idx     = i;
      op_fpu      = v.op;
      rfa         = v.a;
      rfb         = v.b;
      padv_decode = 1'b1;
      @(posedge clk);  // capture edge
      #2;
      padv_decode = 1'b0;
      flush       = v.flush;
      if (v.kind == K_NONE) begin
        repeat (4) begin  // checker flags any output here
          @(posedge clk);
          #2;
          flush = 1'b0;
        end
      end else begin
        while (!(fpu_arith_valid | fpu_cmp_valid)) begin
          @(posedge clk);
          #2;
        end
        repeat (v.stall) begin  // result held meanwhile
          @(posedge clk);
          #2;
        end
        padv_execute = 1'b1;
        @(posedge clk);
        #2;
        padv_execute = 1'b0;
      end
    end
    repeat (2) @(posedge clk);
    $display("results checked: %0d, value errors: %0d, protocol errors: %0d",
             results, value_errors, proto_errors);
    if (value_errors + proto_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+dv
design/fpu_pkg.sv
design/fpu_operand_if.sv
design/fpu_issue.sv
design/fpu_operand_unpack.sv
design/fpu_fcmp.sv
design/fpu_f2i.sv
design/fpu_result_stage.sv
design/fpu_top.sv
dv/fpu_checker.sv
dv/fpu_tb.sv
